// ==== design/qst_pkg.sv ====
`default_nettype none

package qst_pkg;

    //////////////////////////////////////////////////
    // sizes, all derived from the qubit count
    //////////////////////////////////////////////////

    localparam int QUBITS     = 3;
    localparam int NUM_TERMS  = 2 ** QUBITS;    // terms per row
    localparam int ROWS       = 4 ** QUBITS;    // rows in the term table
    localparam int ROW_W      = 2 * QUBITS;
    localparam int COEF_W     = 32;
    localparam int SUM_W      = COEF_W + QUBITS; // guard bits for 8 terms
    localparam int RES_ADDR_W = ROW_W + 1;       // real and imag per row

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [SUM_W-1:0]  sum_t;

    //////////////////////////////////////////////////
    // term coding
    //////////////////////////////////////////////////

    // one coded term: lane, sign and which coefficient
    typedef struct packed {
        logic             imag;      // 1 = imaginary sum
        logic             neg;       // 1 = subtract the coefficient
        logic [ROW_W-1:0] coef_addr;
    } term_t;

    // a term-table row, loaded as raw halves and decoded as terms
    typedef union packed {
        logic [NUM_TERMS*$bits(term_t)-1:0] raw;
        term_t [NUM_TERMS-1:0]               terms;
    } term_row_u;

    // target memory of a host load
    typedef enum logic {
        LOAD_COEF = 1'b0,
        LOAD_TERM = 1'b1
    } load_sel_t;

endpackage

`default_nettype wire

// ==== design/qst_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// host load path, sequencer to term store
interface mem_load_if import qst_pkg::*; ();
    logic                  we;
    load_sel_t             sel;
    logic [RES_ADDR_W-1:0] addr;  // coef: bits 5:0, term: row = addr/2, bit 0 = half
    coef_t                 data;

    modport src (output we, sel, addr, data);
    modport dst (input we, sel, addr, data);
endinterface

// one fetched row, term store to adder tree
interface operand_if import qst_pkg::*; ();
    logic                    valid;
    logic [ROW_W-1:0]        row;
    term_row_u               terms;
    coef_t [NUM_TERMS-1:0]   coefs;  // coefs[k] belongs to terms[k]

    modport src (output valid, row, terms, coefs);
    modport dst (input valid, row, terms, coefs);
endinterface

// scaled row result, adder tree to result memory
interface result_if import qst_pkg::*; ();
    logic             valid;
    logic [ROW_W-1:0] row;
    coef_t            re;
    coef_t            im;

    modport src (output valid, row, re, im);
    modport dst (input valid, row, re, im);
    modport mon (input valid, row);  // sequencer only needs to spot the last row
endinterface

`default_nettype wire

// ==== design/qst_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module qst_sequencer import qst_pkg::*; (
    input  logic                  sysclk,
    input  logic                  sys_reset,
    input  logic                  load_req,
    input  load_sel_t             load_sel,
    input  logic [RES_ADDR_W-1:0] load_addr,
    input  coef_t                 load_data,
    input  logic                  start,
    input  logic                  last,
    output logic                  load_ack,
    output logic                  busy,
    output logic                  done,
    output logic                  run_en,
    mem_load_if.src               ld,
    result_if.mon                 res
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ACK   = 2'd1;  // write done, wait for req low
    localparam logic [1:0] ST_RUN   = 2'd2;  // one row per clock
    localparam logic [1:0] ST_DRAIN = 2'd3;  // rows still in the tree

    logic [1:0] state;
    logic       final_res;

    //////////////////////////////////////////////////
    // host load path
    //////////////////////////////////////////////////

    // the write happens in the cycle the request is seen while idle
    assign ld.we   = (state == ST_IDLE) && load_req;
    assign ld.sel  = load_sel;
    assign ld.addr = load_addr;
    assign ld.data = load_data;

    assign load_ack = (state == ST_ACK);
    assign busy     = (state == ST_RUN) || (state == ST_DRAIN);
    assign run_en   = (state == ST_RUN);

    assign final_res = res.valid && (res.row == ROW_W'(ROWS - 1));

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        if (sys_reset) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_req) begin       // a pending load beats start
                        state <= ST_ACK;
                    end else if (start) begin
                        state <= ST_RUN;
                        done  <= 1'b0;
                    end
                end
                ST_ACK: begin
                    if (!load_req) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RUN: begin
                    if (last) begin            // row 63 issued this cycle
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (final_res) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;        // held until the next start
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/row_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_counter import qst_pkg::*; (
    input  logic             sysclk,
    input  logic             sys_reset,
    input  logic             run_en,
    output logic [ROW_W-1:0] row,
    output logic             last
);

    // wraps back to 0 after the last row, ready for the next run
    always_ff @(posedge sysclk) begin
        if (sys_reset) begin
            row <= '0;
        end else if (run_en) begin
            row <= row + 1'b1;
        end
    end

    assign last = (row == ROW_W'(ROWS - 1));

endmodule

`default_nettype wire

// ==== design/term_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module term_store import qst_pkg::*; (
    input  logic             sysclk,
    input  logic [ROW_W-1:0] row,
    input  logic             issue,  // run_en from the sequencer
    mem_load_if.dst          ld,
    operand_if.src           op
);

    coef_t     coef_mem [ROWS];
    term_row_u term_mem [ROWS];

    term_row_u             rd_row;
    coef_t [NUM_TERMS-1:0] rd_coefs;

    //////////////////////////////////////////////////
    // load writes
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        if (ld.we) begin
            if (ld.sel == LOAD_COEF) begin
                coef_mem[ld.addr[ROW_W-1:0]] <= ld.data;
            end else if (ld.addr[0]) begin
                term_mem[ld.addr[RES_ADDR_W-1:1]].raw[63:32] <= ld.data;  // high half
            end else begin
                term_mem[ld.addr[RES_ADDR_W-1:1]].raw[31:0] <= ld.data;
            end
        end
    end

    //////////////////////////////////////////////////
    // operand fetch
    //////////////////////////////////////////////////

    assign rd_row = term_mem[row];

    // each term picks its own coefficient
    always_comb begin
        for (int k = 0; k < NUM_TERMS; k++) begin
            rd_coefs[k] = coef_mem[rd_row.terms[k].coef_addr];
        end
    end

    // issue is held low through reset, so valid settles low there too
    always_ff @(posedge sysclk) begin
        op.valid <= issue;
        op.row   <= row;
        op.terms <= rd_row;
        op.coefs <= rd_coefs;
    end

endmodule

`default_nettype wire

// ==== design/term_adder_tree.sv ====
`timescale 1ns/100ps
`default_nettype none

module term_adder_tree import qst_pkg::*; (
    input  logic    sysclk,
    input  logic    sys_reset,
    operand_if.dst  op,
    result_if.src   res
);

    // level 0 is the route stage, levels 1..QUBITS are the add levels
    sum_t             re_q  [QUBITS+1][NUM_TERMS];
    sum_t             im_q  [QUBITS+1][NUM_TERMS];
    logic [QUBITS:0]  vld_q;
    logic [ROW_W-1:0] row_q [QUBITS+1];

    sum_t term_val [NUM_TERMS];
    sum_t re_shift;
    sum_t im_shift;

    //////////////////////////////////////////////////
    // sign each term
    //////////////////////////////////////////////////

    // widen first so that negating the most negative value cannot wrap
    always_comb begin
        for (int k = 0; k < NUM_TERMS; k++) begin
            if (op.terms.terms[k].neg) begin
                term_val[k] = -sum_t'(op.coefs[k]);
            end else begin
                term_val[k] = sum_t'(op.coefs[k]);
            end
        end
    end

    //////////////////////////////////////////////////
    // route stage and add levels
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        for (int k = 0; k < NUM_TERMS; k++) begin
            re_q[0][k] <= op.terms.terms[k].imag ? '0 : term_val[k];
            im_q[0][k] <= op.terms.terms[k].imag ? term_val[k] : '0;
        end
        row_q[0] <= op.row;

        for (int l = 1; l <= QUBITS; l++) begin
            for (int k = 0; k < (NUM_TERMS >> l); k++) begin  // halves every level
                re_q[l][k] <= re_q[l-1][2*k] + re_q[l-1][2*k+1];
                im_q[l][k] <= im_q[l-1][2*k] + im_q[l-1][2*k+1];
            end
            row_q[l] <= row_q[l-1];
        end
    end

    always_ff @(posedge sysclk) begin
        if (sys_reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[QUBITS-1:0], op.valid};
        end
    end

    //////////////////////////////////////////////////
    // scale by 2^N, floor
    //////////////////////////////////////////////////

    assign re_shift = re_q[QUBITS][0] >>> QUBITS;
    assign im_shift = im_q[QUBITS][0] >>> QUBITS;

    always_ff @(posedge sysclk) begin
        res.re  <= re_shift[COEF_W-1:0];  // the guard bits are gone after the shift
        res.im  <= im_shift[COEF_W-1:0];
        res.row <= row_q[QUBITS];
    end

    always_ff @(posedge sysclk) begin
        if (sys_reset) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= vld_q[QUBITS];
        end
    end

endmodule

`default_nettype wire

// ==== design/result_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_ram import qst_pkg::*; (
    input  logic                  sysclk,
    input  logic [RES_ADDR_W-1:0] rd_addr,
    output coef_t                 rd_data,
    result_if.dst                 res
);

    coef_t mem [2*ROWS];

    // real at 2*row, imaginary at 2*row+1, both in one cycle
    always_ff @(posedge sysclk) begin
        if (res.valid) begin
            mem[{res.row, 1'b0}] <= res.re;
            mem[{res.row, 1'b1}] <= res.im;
        end
    end

    always_ff @(posedge sysclk) begin
        rd_data <= mem[rd_addr];  // host read, one cycle
    end

endmodule

`default_nettype wire

// ==== design/qst_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module qst_top import qst_pkg::*; (
    input  logic                  sysclk,
    input  logic                  sys_reset,
    input  logic                  load_req,
    input  load_sel_t             load_sel,
    input  logic [RES_ADDR_W-1:0] load_addr,
    input  coef_t                 load_data,
    input  logic                  start,
    input  logic [RES_ADDR_W-1:0] rd_addr,
    output logic                  load_ack,
    output logic                  busy,
    output logic                  done,
    output coef_t                 rd_data
);

    logic             run_en;
    logic [ROW_W-1:0] row;
    logic             last;

    mem_load_if ld_if ();
    operand_if  op_if ();
    result_if   res_if ();

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    qst_sequencer u_seq (
        .sysclk    (sysclk),
        .sys_reset (sys_reset),
        .load_req  (load_req),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .last      (last),
        .load_ack  (load_ack),
        .busy      (busy),
        .done      (done),
        .run_en    (run_en),
        .ld        (ld_if.src),
        .res       (res_if.mon)
    );

    row_counter u_rows (
        .sysclk    (sysclk),
        .sys_reset (sys_reset),
        .run_en    (run_en),
        .row       (row),
        .last      (last)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    term_store u_store (
        .sysclk (sysclk),
        .row    (row),
        .issue  (run_en),
        .ld     (ld_if.dst),
        .op     (op_if.src)
    );

    term_adder_tree u_tree (
        .sysclk    (sysclk),
        .sys_reset (sys_reset),
        .op        (op_if.dst),
        .res       (res_if.src)
    );

    result_ram u_res (
        .sysclk  (sysclk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .res     (res_if.dst)
    );

endmodule

`default_nettype wire

// ==== bench/qst_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module qst_props import qst_pkg::*; (
    input logic sysclk,
    input logic sys_reset,
    input logic load_req,
    input logic load_ack,
    input logic start,
    input logic busy,
    input logic done,
    input logic run_en
);

    int             fail_count = 0;
    logic [ROW_W:0] run_cycles;    // rows issued so far in this run

    //////////////////////////////////////////////////
    // load handshake
    //////////////////////////////////////////////////

    // idle request is answered on the next clock
    ack_follows_req: assert property (@(posedge sysclk) disable iff (sys_reset)
        (load_req && !load_ack && !busy) |=> load_ack)
        else begin
            $error("load_ack did not follow load_req while idle");
            fail_count++;
        end

    ack_drops: assert property (@(posedge sysclk) disable iff (sys_reset)
        (load_ack && !load_req) |=> !load_ack)
        else begin
            $error("load_ack held after load_req dropped");
            fail_count++;
        end

    //////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////

    always @(posedge sysclk) begin
        if (sys_reset || !run_en) begin
            run_cycles <= '0;
        end else begin
            run_cycles <= run_cycles + 1'b1;
        end
    end

    start_runs: assert property (@(posedge sysclk) disable iff (sys_reset)
        (start && !busy && !load_ack && !load_req) |=> (busy && !done))
        else begin
            $error("start while idle did not begin a run");
            fail_count++;
        end

    // one row per clock, every row of the table exactly once
    run_len: assert property (@(posedge sysclk) disable iff (sys_reset)
        $fell(run_en) |-> (run_cycles == (ROW_W + 1)'(ROWS)))
        else begin
            $error("run_en was not high for one cycle per row");
            fail_count++;
        end

    busy_done_excl: assert property (@(posedge sysclk) disable iff (sys_reset)
        !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== bench/tb_qst.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_qst import qst_pkg::*;;

    localparam int EDGE_LOADS = 4 + 6;                          // 4 coefs, 3 rows of 2 halves
    localparam int N_LOADS    = ROWS + 2 * ROWS + EDGE_LOADS + 1;
    localparam int N_RUNS     = 4;
    localparam int WATCHDOG_CYCLES = N_LOADS * 8 + N_RUNS * 200;  // run plus readout

    logic                  sysclk;
    logic                  sys_reset;
    logic                  load_req;
    load_sel_t             load_sel;
    logic [RES_ADDR_W-1:0] load_addr;
    coef_t                 load_data;
    logic                  start;
    logic [RES_ADDR_W-1:0] rd_addr;
    logic                  load_ack;
    logic                  busy;
    logic                  done;
    coef_t                 rd_data;

    coef_t       coef_model [ROWS];
    logic [63:0] term_model [ROWS];    // term k of a row sits in byte k
    logic [31:0] rng_state = 32'h4d77;

    qst_top uut (.*);

    bind qst_sequencer qst_props u_props (
        .sysclk    (sysclk),
        .sys_reset (sys_reset),
        .load_req  (load_req),
        .load_ack  (load_ack),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .run_en    (run_en)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("timeout: the DUT did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [7:0] term_code(input logic imag, input logic neg,
                                             input logic [5:0] addr);
        return {imag, neg, addr};    // lane, sign, coefficient
    endfunction

    // reference for one result word as a 35-bit signed sum floor divided by 8
    function automatic coef_t expected_word(input logic [RES_ADDR_W-1:0] addr);
        logic [63:0] row_bits;
        logic [7:0]  code;
        sum_t        acc;
        sum_t        val;
        row_bits = term_model[addr[RES_ADDR_W-1:1]];
        acc = '0;
        for (int k = 0; k < NUM_TERMS; k++) begin
            code = row_bits[8*k +: 8];
            if (code[7] == addr[0]) begin    // odd address is the imaginary lane
                val = sum_t'(coef_model[code[5:0]]);
                if (code[6]) begin
                    val = -val;
                end
                acc = acc + val;
            end
        end
        acc = acc >>> QUBITS;
        return acc[COEF_W-1:0];
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_coef(input string name, input coef_t got, input coef_t exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // host side tasks
    //////////////////////////////////////////////////

    task automatic do_load(input load_sel_t sel, input logic [RES_ADDR_W-1:0] addr,
                           input coef_t data);
        @(posedge sysclk);
        load_req  <= 1'b1;
        load_sel  <= sel;
        load_addr <= addr;
        load_data <= data;
        @(negedge sysclk);
        check_flag("load_ack", load_ack, 1'b0);    // request not seen yet
        while (load_ack !== 1'b1) @(negedge sysclk);
        @(posedge sysclk);
        load_req <= 1'b0;
        @(negedge sysclk);
        check_flag("load_ack", load_ack, 1'b1);    // held until req low is seen
        while (load_ack !== 1'b0) @(negedge sysclk);
    endtask

    task automatic load_coef(input logic [ROW_W-1:0] idx, input coef_t val);
        coef_model[idx] = val;
        do_load(LOAD_COEF, RES_ADDR_W'(idx), val);
    endtask

    task automatic load_term_half(input logic [RES_ADDR_W-1:0] addr, input coef_t data);
        term_model[addr[RES_ADDR_W-1:1]][32*addr[0] +: 32] = data;
        do_load(LOAD_TERM, addr, data);
    endtask

    task automatic load_term_row(input logic [ROW_W-1:0] row, input logic [63:0] bits);
        load_term_half({row, 1'b0}, bits[31:0]);
        load_term_half({row, 1'b1}, bits[63:32]);
    endtask

    task automatic start_run();
        @(posedge sysclk);
        start <= 1'b1;
        @(posedge sysclk);
        start <= 1'b0;
        @(negedge sysclk);
        check_flag("busy", busy, 1'b1);
        check_flag("done", done, 1'b0);
    endtask

    // ack_blocked means a load is pending that must not be answered yet
    task automatic wait_done(input logic ack_blocked);
        while (done !== 1'b1) begin
            @(negedge sysclk);
            if (ack_blocked) begin
                check_flag("load_ack", load_ack, 1'b0);
            end
        end
        check_flag("busy", busy, 1'b0);
    endtask

    // one address per clock with the data one clock later
    task automatic check_results();
        for (int a = 0; a <= 2 * ROWS; a++) begin
            @(posedge sysclk);
            if (a < 2 * ROWS) begin
                rd_addr <= RES_ADDR_W'(a);
            end
            @(negedge sysclk);
            if (a > 0) begin
                check_coef($sformatf("rd_data[%0d]", a - 1), rd_data,
                           expected_word(RES_ADDR_W'(a - 1)));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin : main
        logic [ROW_W-1:0] bp_idx;
        coef_t            bp_val;

        sys_reset = 1'b1;
        load_req  = 1'b0;
        load_sel  = LOAD_COEF;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        rd_addr   = '0;
        repeat (4) @(posedge sysclk);
        sys_reset <= 1'b0;
        @(negedge sysclk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("load_ack", load_ack, 1'b0);

        for (int i = 0; i < ROWS; i++) begin
            load_coef(ROW_W'(i), coef_t'(next_rand()));
        end
        for (int h = 0; h < 2 * ROWS; h++) begin
            load_term_half(RES_ADDR_W'(h), next_rand());
        end
        start_run();
        wait_done(1'b0);
        check_results();

        // extreme coefficients exercise the guard bits and the floor
        load_coef(6'd0, 32'h8000_0000);
        load_coef(6'd1, 32'h7fff_ffff);
        load_coef(6'd2, 32'hffff_ffff);
        load_coef(6'd3, 32'd5);
        load_term_row(6'd0, {8{term_code(1'b0, 1'b0, 6'd1)}});  // 8 x max in the real lane
        load_term_row(6'd1, {8{term_code(1'b1, 1'b0, 6'd0)}});  // 8 x min in the imag lane
        load_term_row(6'd2, {{7{term_code(1'b1, 1'b0, 6'd3)}}, term_code(1'b0, 1'b0, 6'd2)});
        start_run();
        wait_done(1'b0);
        check_results();

        // load raised mid run waits for done, then lands in the next run
        bp_idx = term_model[10][5:0];
        bp_val = coef_t'(next_rand());
        start_run();
        @(posedge sysclk);
        load_req  <= 1'b1;
        load_sel  <= LOAD_COEF;
        load_addr <= RES_ADDR_W'(bp_idx);
        load_data <= bp_val;
        wait_done(1'b1);
        while (load_ack !== 1'b1) @(negedge sysclk);
        @(posedge sysclk);
        load_req <= 1'b0;
        while (load_ack !== 1'b0) @(negedge sysclk);
        check_results();
        coef_model[bp_idx] = bp_val;
        start_run();
        wait_done(1'b0);
        check_results();

        if (uut.u_seq.u_props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("%0d sequencer assertion failures", uut.u_seq.u_props.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/qst_pkg.sv
design/qst_ifs.sv
design/qst_sequencer.sv
design/row_counter.sv
design/term_store.sv
design/term_adder_tree.sv
design/result_ram.sv
design/qst_top.sv
bench/qst_props.sv
bench/tb_qst.sv

// ==== Bender.yml ====
package:
  name: qst_rho

sources:
  - files:
      - design/qst_pkg.sv
      - design/qst_ifs.sv
      - design/qst_sequencer.sv
      - design/row_counter.sv
      - design/term_store.sv
      - design/term_adder_tree.sv
      - design/result_ram.sv
      - design/qst_top.sv
  - target: test
    files:
      - bench/qst_props.sv
      - bench/tb_qst.sv
